// ==== rtl/buf_pkg.sv ====
// payload types, lane depths and the hardened register file shape for the lane buffer

package buf_pkg;

  // ==========================================================================
  // payload types
  // ==========================================================================

  // lane a carries full data words
  typedef logic [31:0] data_t;

  // lane b carries control bytes
  typedef logic [7:0] ctrl_t;

  // ==========================================================================
  // lane depths
  // ==========================================================================

  // entries in the data lane
  localparam int lane_a_els_lp = 16;

  // entries in the control lane
  localparam int lane_b_els_lp = 4;

  // ==========================================================================
  // hardened storage shape
  // ==========================================================================

  // only one register file shape is hardened in this library
  // a storage request of exactly this many entries of exactly this width
  // maps to the one-hot register file, anything else falls back to a
  // plain array
  localparam int hard_els_lp = 4;

  localparam int hard_width_lp = 8;

endpackage

// ==== rtl/fifo_1r1w.sv ====
// circular FIFO with head and tail pointers and an occupancy count over the 1r1w storage wrapper

module fifo_1r1w
  #(
    parameter type elem_t = logic [7:0],
    parameter int  els_p  = 2
  )
  (
    input  logic  w_clk_i,
    input  logic  reset_i,

    // enqueue side
    input  logic  v_i,
    input  elem_t data_i,
    output logic  full_o,

    // dequeue side
    output logic  v_o,
    output elem_t data_o,
    input  logic  yumi_i
  );

  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

  // count runs from zero to els_p inclusive, so it needs one more state
  localparam int cnt_width_lp = $clog2(els_p + 1);

  localparam logic [addr_width_lp-1:0] last_addr_lp = addr_width_lp'(els_p - 1);
  localparam logic [cnt_width_lp-1:0]  full_cnt_lp  = cnt_width_lp'(els_p);

  logic [addr_width_lp-1:0] head_r;
  logic [addr_width_lp-1:0] tail_r;
  logic [cnt_width_lp-1:0]  count_r;

  logic enq;
  logic deq;

  // ==========================================================================
  // status and acceptance
  // ==========================================================================

  // both levels come from the registered count, so a full FIFO refuses an
  // enqueue even on an edge where it also gives up its head
  assign full_o = (count_r == full_cnt_lp);
  assign v_o    = (count_r != '0);

  assign enq = v_i & ~full_o;
  assign deq = yumi_i & v_o;

  // ==========================================================================
  // pointers and count
  // ==========================================================================

  always_ff @(posedge w_clk_i)
  begin
    if (reset_i)
    begin
      head_r  <= '0;
      tail_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      // depths need not be a power of two, so wrap explicitly
      if (enq)
      begin
        tail_r <= (tail_r == last_addr_lp) ? '0 : tail_r + 1'b1;
      end

      if (deq)
      begin
        head_r <= (head_r == last_addr_lp) ? '0 : head_r + 1'b1;
      end

      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // ==========================================================================
  // storage
  // ==========================================================================

  // the head slot is only written while the FIFO is empty, and the read
  // strobe is low then, so the two ports never meet on one live entry
  mem_1r1w #(
    .elem_t(elem_t),
    .els_p (els_p)
  ) mem (
    .w_clk_i (w_clk_i),
    .w_v_i   (enq),
    .w_addr_i(tail_r),
    .w_data_i(data_i),
    .r_v_i   (v_o),
    .r_addr_i(head_r),
    .r_data_o(data_o)
  );

endmodule

// ==== rtl/lane_buffer.sv ====
// two-lane elastic buffer top holding a data word lane and a control byte lane

module lane_buffer
  (
    input  logic            w_clk_i,
    input  logic            reset_i,

    // ========================================================================
    // lane a, data words
    // ========================================================================

    input  logic            a_v_i,
    input  buf_pkg::data_t  a_data_i,
    output logic            a_full_o,

    output logic            a_v_o,
    output buf_pkg::data_t  a_data_o,
    input  logic            a_yumi_i,

    // ========================================================================
    // lane b, control bytes
    // ========================================================================

    input  logic            b_v_i,
    input  buf_pkg::ctrl_t  b_data_i,
    output logic            b_full_o,

    output logic            b_v_o,
    output buf_pkg::ctrl_t  b_data_o,
    input  logic            b_yumi_i
  );

  // the two lanes run independently and share only clock and reset

  // data lane shape is not hardened, so it lands on the plain array
  fifo_1r1w #(
    .elem_t(buf_pkg::data_t),
    .els_p (buf_pkg::lane_a_els_lp)
  ) lane_a (
    .w_clk_i(w_clk_i),
    .reset_i(reset_i),
    .v_i    (a_v_i),
    .data_i (a_data_i),
    .full_o (a_full_o),
    .v_o    (a_v_o),
    .data_o (a_data_o),
    .yumi_i (a_yumi_i)
  );

  // control lane matches the hardened shape and gets the one-hot register file
  fifo_1r1w #(
    .elem_t(buf_pkg::ctrl_t),
    .els_p (buf_pkg::lane_b_els_lp)
  ) lane_b (
    .w_clk_i(w_clk_i),
    .reset_i(reset_i),
    .v_i    (b_v_i),
    .data_i (b_data_i),
    .full_o (b_full_o),
    .v_o    (b_v_o),
    .data_o (b_data_o),
    .yumi_i (b_yumi_i)
  );

endmodule

// ==== rtl/mem_1r1w.sv ====
// one read port, one write port storage wrapper choosing the register file or a plain array

module mem_1r1w
  #(
    parameter type elem_t = logic [7:0],
    parameter int  els_p  = 2
  )
  (
    input  logic                     w_clk_i,

    input  logic                     w_v_i,
    input  logic [addr_width_lp-1:0] w_addr_i,
    input  elem_t                    w_data_i,

    input  logic                     r_v_i,
    input  logic [addr_width_lp-1:0] r_addr_i,
    output elem_t                    r_data_o
  );

  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

  // ==========================================================================
  // implementation select
  // ==========================================================================

  if (els_p == buf_pkg::hard_els_lp && $bits(elem_t) == buf_pkg::hard_width_lp)
  begin : hard

    logic [buf_pkg::hard_els_lp-1:0] w_sel;
    logic [buf_pkg::hard_els_lp-1:0] r_sel;

    // the strobe itself is the bit shifted into place, so an idle port
    // decodes to an all-zero select
    assign w_sel = {{(buf_pkg::hard_els_lp-1){1'b0}}, w_v_i} << w_addr_i;
    assign r_sel = {{(buf_pkg::hard_els_lp-1){1'b0}}, r_v_i} << r_addr_i;

    rf_1r1w_onehot #(
      .elem_t(elem_t)
    ) rf (
      .w_clk_i    (w_clk_i),
      .write_sel_i(w_sel),
      .w_data_i   (w_data_i),
      .read_sel_i (r_sel),
      .r_data_o   (r_data_o)
    );

  end
  else
  begin : synth

    // read enable has no meaning for a plain array
    mem_1r1w_synth #(
      .elem_t(elem_t),
      .els_p (els_p)
    ) array (
      .w_clk_i (w_clk_i),
      .w_v_i   (w_v_i),
      .w_addr_i(w_addr_i),
      .w_data_i(w_data_i),
      .r_addr_i(r_addr_i),
      .r_data_o(r_data_o)
    );

  end

endmodule

// ==== rtl/mem_1r1w_synth.sv ====
// plain indexed array with one synchronous write port and one asynchronous read port

module mem_1r1w_synth
  #(
    parameter type elem_t = logic [7:0],
    parameter int  els_p  = 2
  )
  (
    input  logic                     w_clk_i,

    input  logic                     w_v_i,
    input  logic [addr_width_lp-1:0] w_addr_i,
    input  elem_t                    w_data_i,

    input  logic [addr_width_lp-1:0] r_addr_i,
    output elem_t                    r_data_o
  );

  // a single entry array still needs one address bit
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

  elem_t mem_r [els_p];

  // write lands on the edge
  always_ff @(posedge w_clk_i)
  begin
    if (w_v_i)
    begin
      mem_r[w_addr_i] <= w_data_i;
    end
  end

  // read is a straight index, no output register
  assign r_data_o = mem_r[r_addr_i];

endmodule

// ==== rtl/rf_1r1w_onehot.sv ====
// register file of the hardened shape, written and read through one-hot select vectors

module rf_1r1w_onehot
  #(
    parameter type elem_t = logic [7:0]
  )
  (
    input  logic                            w_clk_i,

    input  logic [buf_pkg::hard_els_lp-1:0] write_sel_i,
    input  elem_t                           w_data_i,

    input  logic [buf_pkg::hard_els_lp-1:0] read_sel_i,
    output elem_t                           r_data_o
  );

  // storage rows, no reset on the contents
  elem_t rows_r [buf_pkg::hard_els_lp];

  // wired-or read bus, one gated row per select bit
  logic [buf_pkg::hard_width_lp-1:0] rd_bus;

  // ==========================================================================
  // write side
  // ==========================================================================

  // each row has its own enable, a zero select vector writes nothing
  always_ff @(posedge w_clk_i)
  begin
    for (int i = 0; i < buf_pkg::hard_els_lp; i++)
    begin
      if (write_sel_i[i])
      begin
        rows_r[i] <= w_data_i;
      end
    end
  end

  // ==========================================================================
  // read side
  // ==========================================================================

  // a hardened array drives its bit lines through and-or gating, so the
  // read is purely combinational and an idle select reads back zero
  always_comb
  begin
    rd_bus = '0;
    for (int i = 0; i < buf_pkg::hard_els_lp; i++)
    begin
      rd_bus = rd_bus | (rows_r[i] & {buf_pkg::hard_width_lp{read_sel_i[i]}});
    end
  end

  assign r_data_o = elem_t'(rd_bus);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the lane buffer testbench with Verilator, runs it and reports the verdict

set -u

# all paths in the file list are relative to the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module lane_buffer_tb \
  -f tb.f
status=$?
if [ "$status" -ne 0 ]
then
  echo "build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vlane_buffer_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]
then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its verdict on a line of its own
if printf '%s\n' "$output" | grep -qx "Simulation PASSED"
then
  exit 0
else
  exit 1
fi

// ==== tb.f ====
rtl/buf_pkg.sv
rtl/rf_1r1w_onehot.sv
rtl/mem_1r1w_synth.sv
rtl/mem_1r1w.sv
rtl/fifo_1r1w.sv
rtl/lane_buffer.sv
verification/lane_buffer_tb.sv

// ==== verification/lane_buffer_tb.sv ====
// testbench for the two-lane buffer with clock, reset, seeded random stimulus, queue models and checks

module lane_buffer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles_lp = 16;
  localparam int phase_cycles_lp = 400;
  localparam int phase_count_lp  = 4;
  localparam int timeout_lp      = reset_cycles_lp + phase_count_lp * phase_cycles_lp + 100;

  logic w_clk;
  logic reset;

  logic           a_enq_v;
  buf_pkg::data_t a_enq_data;
  logic           a_full;
  logic           a_head_v;
  buf_pkg::data_t a_head_data;
  logic           a_deq_yumi;

  logic           b_enq_v;
  buf_pkg::ctrl_t b_enq_data;
  logic           b_full;
  logic           b_head_v;
  buf_pkg::ctrl_t b_head_data;
  logic           b_deq_yumi;

  // reference queues, one per lane
  buf_pkg::data_t a_model [$];
  buf_pkg::ctrl_t b_model [$];

  // edge actions decided half a cycle ahead from the driven inputs
  logic           a_push;
  logic           a_pop;
  buf_pkg::data_t a_push_data;
  logic           b_push;
  logic           b_pop;
  buf_pkg::ctrl_t b_push_data;

  int enq_pct;
  int deq_pct;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  // event tallies per lane, index 0 is lane a and index 1 is lane b
  int full_seen    [2];
  int full_refused [2];
  int both_mid     [2];
  int deq_empty    [2];

  lane_buffer lane_buffer_i (
    .w_clk_i (w_clk),
    .reset_i (reset),
    .a_v_i   (a_enq_v),
    .a_data_i(a_enq_data),
    .a_full_o(a_full),
    .a_v_o   (a_head_v),
    .a_data_o(a_head_data),
    .a_yumi_i(a_deq_yumi),
    .b_v_i   (b_enq_v),
    .b_data_i(b_enq_data),
    .b_full_o(b_full),
    .b_v_o   (b_head_v),
    .b_data_o(b_head_data),
    .b_yumi_i(b_deq_yumi)
  );

  always #4 w_clk = ~w_clk;

  // ==========================================================================
  // checks
  // ==========================================================================

  task automatic verify_level(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("Mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_data(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("Mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic require_event(input string what, input int hits);
    checks++;
    assert (hits > 0)
    else
    begin
      errors++;
      $display("the run never produced this case: %s", what);
    end
  endtask

  // levels follow the model count, and the head is only defined while valid
  task automatic check_lanes();
    verify_level("a_v_o", a_model.size() != 0, a_head_v);
    verify_level("a_full_o", a_model.size() == buf_pkg::lane_a_els_lp, a_full);
    if (a_model.size() != 0)
    begin
      compare_data("a_data_o", a_model[0], a_head_data);
    end
    verify_level("b_v_o", b_model.size() != 0, b_head_v);
    verify_level("b_full_o", b_model.size() == buf_pkg::lane_b_els_lp, b_full);
    if (b_model.size() != 0)
    begin
      compare_data("b_data_o", 32'(b_model[0]), 32'(b_head_data));
    end
  endtask

  // ==========================================================================
  // model
  // ==========================================================================

  function automatic void tally_events(input int lane, input int size, input int depth,
                                       input logic v, input logic yumi);
    if (size == depth)
    begin
      full_seen[lane]++;
    end
    if (size == depth && v && yumi)
    begin
      full_refused[lane]++;
    end
    if (size > 0 && size < depth && v && yumi)
    begin
      both_mid[lane]++;
    end
    if (size == 0 && yumi)
    begin
      deq_empty[lane]++;
    end
  endfunction

  // acceptance uses the count before the edge, so full refuses even with a dequeue
  task automatic judge_acceptance();
    a_push      = a_enq_v && (a_model.size() < buf_pkg::lane_a_els_lp);
    a_pop       = a_deq_yumi && (a_model.size() > 0);
    a_push_data = a_enq_data;
    b_push      = b_enq_v && (b_model.size() < buf_pkg::lane_b_els_lp);
    b_pop       = b_deq_yumi && (b_model.size() > 0);
    b_push_data = b_enq_data;
    tally_events(0, a_model.size(), buf_pkg::lane_a_els_lp, a_enq_v, a_deq_yumi);
    tally_events(1, b_model.size(), buf_pkg::lane_b_els_lp, b_enq_v, b_deq_yumi);
  endtask

  task automatic apply_edge();
    if (a_pop)
    begin
      void'(a_model.pop_front());
    end
    if (a_push)
    begin
      a_model.push_back(a_push_data);
    end
    if (b_pop)
    begin
      void'(b_model.pop_front());
    end
    if (b_push)
    begin
      b_model.push_back(b_push_data);
    end
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================

  task automatic set_rates(input int phase);
    case (phase)
      0:
      begin
        enq_pct = 50;
        deq_pct = 50;
      end
      1:
      begin
        enq_pct = 90;
        deq_pct = 10;
      end
      2:
      begin
        enq_pct = 10;
        deq_pct = 90;
      end
      default:
      begin
        enq_pct = 75;
        deq_pct = 75;
      end
    endcase
  endtask

  task automatic drive_stimulus();
    a_enq_v    <= ($urandom % 100) < enq_pct;
    a_enq_data <= $urandom;
    a_deq_yumi <= ($urandom % 100) < deq_pct;
    b_enq_v    <= ($urandom % 100) < enq_pct;
    b_enq_data <= 8'($urandom);
    b_deq_yumi <= ($urandom % 100) < deq_pct;
  endtask

  initial
  begin
    void'($urandom(32'hb093));
    w_clk      = 1'b0;
    reset      = 1'b1;
    a_enq_v    = 1'b0;
    a_enq_data = '0;
    a_deq_yumi = 1'b0;
    b_enq_v    = 1'b0;
    b_enq_data = '0;
    b_deq_yumi = 1'b0;
    enq_pct    = 0;
    deq_pct    = 0;

    repeat (reset_cycles_lp - 1) @(posedge w_clk);
    @(negedge w_clk);
    check_lanes();
    @(posedge w_clk);
    reset <= 1'b0;

    for (int p = 0; p < phase_count_lp; p++)
    begin
      set_rates(p);
      repeat (phase_cycles_lp)
      begin
        @(negedge w_clk);
        check_lanes();
        judge_acceptance();
        @(posedge w_clk);
        apply_edge();
        drive_stimulus();
      end
    end

    require_event("lane a full", full_seen[0]);
    require_event("lane b full", full_seen[1]);
    require_event("lane a enqueue and dequeue while full", full_refused[0]);
    require_event("lane b enqueue and dequeue while full", full_refused[1]);
    require_event("lane a enqueue and dequeue at mid occupancy", both_mid[0]);
    require_event("lane b enqueue and dequeue at mid occupancy", both_mid[1]);
    require_event("lane a dequeue while empty", deq_empty[0]);
    require_event("lane b dequeue while empty", deq_empty[1]);

    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // the run is bounded by reset, all phases and a small margin
  always @(posedge w_clk)
  begin
    cycles++;
    if (cycles >= timeout_lp)
    begin
      errors++;
      $display("timeout: the run did not finish within %0d cycles", timeout_lp);
      $display("checks run %0d, errors %0d", checks, errors);
      $display("Simulation FAILED");
      $finish;
    end
  end

endmodule
